//--- hdl/args_subparser.sv
// Argument subparser that reads decimal digits up to the newline and builds the value
module args_subparser import reader_pkg::*, parser_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       start,
	input  rd_status_t status,
	input  char_t      rd_char,
	output logic       rd_trigger,
	output logic       args_done,
	output value_t     arg,
	output logic       args_err
);

	logic   busy;
	logic   seen_digit;
	value_t acc;
	value_t acc_next;
	char_t  digit;
	logic   is_digit;

	assign digit    = rd_char - CHAR_0;
	assign is_digit = (rd_char >= CHAR_0) && (rd_char <= CHAR_9);
	// Ten times the value plus the digit, wraps modulo 2^VALUE_W
	assign acc_next = (acc << 3) + (acc << 1) + value_t'(digit);

	// One read per character while busy
	assign rd_trigger = busy && status.rdy && !status.empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy       <= 1'b0;
			seen_digit <= 1'b0;
			acc        <= '0;
			args_done  <= 1'b0;
			arg        <= '0;
			args_err   <= 1'b0;
		end else begin
			args_done <= 1'b0;
			if (start) begin
				busy       <= 1'b1;
				seen_digit <= 1'b0;
				acc        <= '0;
			end
			else if (busy && status.done) begin
				if (is_digit) begin
					acc        <= acc_next;
					seen_digit <= 1'b1;
				end
				// Newline ends the argument, bare newline is an error
				// Any other character stops here and leaves the rest of the line
				else begin
					busy      <= 1'b0;
					args_done <= 1'b1;
					arg       <= acc;
					args_err  <= (rd_char != CHAR_NL) || !seen_digit;
				end
			end
		end
	end

endmodule : args_subparser

//--- hdl/char_reader.sv
// Input-side character FIFO that buffers incoming bytes and presents one per read trigger
module char_reader import reader_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  char_t      in_char,
	input  logic       in_valid,
	output logic       in_full,
	input  logic       rd_trigger,
	output rd_status_t rd_status,
	output char_t      rd_char
);

	char_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             done;
	logic             push;
	logic             pop;

	// Status toward the consumers
	// Reader is busy only in the cycle that presents a character
	assign rd_status.done  = done;
	assign rd_status.rdy   = !done;
	assign rd_status.empty = (count == '0);
	assign in_full         = (count == (PTR_W+1)'(FIFO_DEPTH));

	// Writes while full are dropped
	assign push = in_valid && !in_full;
	// Triggers while busy or empty are ignored
	assign pop  = rd_trigger && rd_status.rdy && !rd_status.empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			done   <= 1'b0;
		end else begin
			done <= pop;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Occupancy only moves when exactly one side is active
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and presentation register
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_char;
		// Held until the next pop
		if (pop)
			rd_char <= mem[rd_ptr];
	end

	// A character takes at least two cycles, so done cannot repeat back to back
	a_done_single: assert property (@(posedge clk) disable iff (!arst_n)
		rd_status.done |=> !rd_status.done)
		else $error("char_reader: done high in two consecutive cycles");

endmodule : char_reader

//--- hdl/cmd_executor.sv
// Output stage that applies each parsed command to the value register and flags the outcome
module cmd_executor import parser_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  result_t result,
	input  logic    result_valid,
	output value_t  out_value,
	output logic    out_valid,
	output logic    out_error
);

	value_t next_value;

	// Register update for a well-formed line
	always_comb begin
		next_value = out_value;
		case (result.cmd)
			CMD_SET: next_value = result.arg;
			// Sum wraps at the register width
			CMD_ADD: next_value = out_value + result.arg;
			CMD_CLR: next_value = '0;
			// Report leaves the register as is
			default: next_value = out_value;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_value <= '0;
			out_valid <= 1'b0;
			out_error <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			out_error <= 1'b0;
			if (result_valid) begin
				// Erroneous line keeps the register
				if (result.err)
					out_error <= 1'b1;
				else begin
					out_valid <= 1'b1;
					out_value <= next_value;
				end
			end
		end
	end

endmodule : cmd_executor

//--- hdl/cmd_subparser.sv
// Command subparser that reads one letter from the reader and decodes the command code
module cmd_subparser import reader_pkg::*, parser_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       start,
	input  rd_status_t status,
	input  char_t      rd_char,
	output logic       rd_trigger,
	output logic       cmd_done,
	output cmd_e       cmd,
	output logic       cmd_err
);

	logic busy;
	cmd_e dec_cmd;
	logic dec_bad;

	// Request as soon as the reader is idle and has data
	// rdy drops in the done cycle, so only one read goes out
	assign rd_trigger = busy && status.rdy && !status.empty;

	// Letter decode
	always_comb begin
		dec_cmd = CMD_SET;
		dec_bad = 1'b0;
		case (rd_char)
			CHAR_S:  dec_cmd = CMD_SET;
			CHAR_A:  dec_cmd = CMD_ADD;
			CHAR_C:  dec_cmd = CMD_CLR;
			CHAR_R:  dec_cmd = CMD_RD;
			default: dec_bad = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= 1'b0;
			cmd_done <= 1'b0;
			cmd      <= CMD_SET;
			cmd_err  <= 1'b0;
		end else begin
			cmd_done <= 1'b0;
			if (start)
				busy <= 1'b1;
			// Letter is on rd_char in the done cycle
			else if (busy && status.done) begin
				busy     <= 1'b0;
				cmd_done <= 1'b1;
				cmd      <= dec_cmd;
				cmd_err  <= dec_bad;
			end
		end
	end

endmodule : cmd_subparser

//--- hdl/main_parser.sv
// Line-level FSM that sequences the subparsers, checks separators and discards bad lines
module main_parser import reader_pkg::*, parser_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  rd_status_t status,
	input  char_t      rd_char,
	output logic       rd_trigger,
	output logic       connect_cmd,
	output logic       connect_args,
	output logic       cmd_start,
	output logic       args_start,
	input  logic       cmd_done,
	input  cmd_e       cmd,
	input  logic       cmd_err,
	input  logic       args_done,
	input  value_t     arg,
	input  logic       args_err,
	output result_t    result,
	output logic       result_valid
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CMD,
		ST_SEP,
		ST_ARG,
		ST_DRAIN,
		ST_REPORT
	} state_e;

	state_e state;
	logic   is_nl;
	logic   sep_ok;

	// rd_char still holds the last consumed character
	assign is_nl  = (rd_char == CHAR_NL);
	// Set and add take a space, clear and report end the line
	assign sep_ok = (result.cmd == CMD_SET || result.cmd == CMD_ADD) ?
		(rd_char == CHAR_SP) : is_nl;

	// Main parser reads only the separator and the discarded tail
	assign rd_trigger   = (state == ST_SEP || state == ST_DRAIN) && status.rdy && !status.empty;
	assign result_valid = (state == ST_REPORT);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= ST_IDLE;
			connect_cmd  <= 1'b0;
			connect_args <= 1'b0;
			cmd_start    <= 1'b0;
			args_start   <= 1'b0;
			result       <= '0;
		end else begin
			cmd_start  <= 1'b0;
			args_start <= 1'b0;
			case (state)
				// New line starts once a character is waiting
				ST_IDLE: if (!status.empty) begin
					result      <= '0;
					connect_cmd <= 1'b1;
					cmd_start   <= 1'b1;
					state       <= ST_CMD;
				end
				ST_CMD: if (cmd_done) begin
					connect_cmd <= 1'b0;
					result.cmd  <= cmd;
					if (cmd_err) begin
						result.err <= 1'b1;
						state      <= is_nl ? ST_REPORT : ST_DRAIN;
					end
					else
						state <= ST_SEP;
				end
				ST_SEP: if (status.done) begin
					if (!sep_ok) begin
						result.err <= 1'b1;
						state      <= is_nl ? ST_REPORT : ST_DRAIN;
					end
					else if (is_nl)
						state <= ST_REPORT;
					else begin
						connect_args <= 1'b1;
						args_start   <= 1'b1;
						state        <= ST_ARG;
					end
				end
				ST_ARG: if (args_done) begin
					connect_args <= 1'b0;
					result.arg   <= arg;
					result.err   <= args_err;
					// Rest of the line is dropped unless the newline was already read
					state        <= (args_err && !is_nl) ? ST_DRAIN : ST_REPORT;
				end
				// Discard up to and including the newline
				ST_DRAIN: if (status.done && is_nl)
					state <= ST_REPORT;
				ST_REPORT: state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	// Executor expects exactly one result per line
	a_result_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		result_valid |=> !result_valid)
		else $error("main_parser: result_valid longer than one cycle");

endmodule : main_parser

//--- hdl/parser_inner_connect.sv
// Combinational switch that hands the shared reader to the main parser or one subparser
module parser_inner_connect import reader_pkg::*; (
	input  logic       connect_cmd,
	input  logic       connect_args,
	input  rd_status_t rd_status,
	input  logic       main_rd_trigger,
	input  logic       cmd_rd_trigger,
	input  logic       args_rd_trigger,

	output logic       rd_trigger,
	output rd_status_t main_status,
	output rd_status_t cmd_status,
	output rd_status_t args_status
);

	always_comb begin
		// Unconnected consumers see an idle, silent reader
		rd_trigger  = 1'b0;
		main_status = '0;
		cmd_status  = '0;
		args_status = '0;

		// Main parser raises at most one connect flag
		a_one_connect: assert (!(connect_cmd && connect_args))
			else $error("parser_inner_connect: both subparsers connected");

		// Command subparser wins over the argument subparser
		if (connect_cmd) begin
			rd_trigger = cmd_rd_trigger;
			cmd_status = rd_status;
		end
		else if (connect_args) begin
			rd_trigger  = args_rd_trigger;
			args_status = rd_status;
		end
		// Main parser owns the reader otherwise
		else begin
			rd_trigger  = main_rd_trigger;
			main_status = rd_status;
		end
	end

endmodule : parser_inner_connect

//--- hdl/parser_pkg.sv
// Command codes, character constants and parsed-line record shared by the parser and executor
package parser_pkg;

	// Width of arguments and of the value register
	localparam int VALUE_W = 16;

	typedef logic [VALUE_W-1:0] value_t;

	// Command codes of the four supported commands
	typedef enum logic [1:0] {
		CMD_SET = 2'd0,
		CMD_ADD = 2'd1,
		CMD_CLR = 2'd2,
		CMD_RD  = 2'd3
	} cmd_e;

	// Separators and digit range
	localparam logic [7:0] CHAR_NL = 8'h0A;
	localparam logic [7:0] CHAR_SP = 8'h20;
	localparam logic [7:0] CHAR_0  = 8'h30;
	localparam logic [7:0] CHAR_9  = 8'h39;

	// Upper-case command letters
	localparam logic [7:0] CHAR_S = 8'h53;
	localparam logic [7:0] CHAR_A = 8'h41;
	localparam logic [7:0] CHAR_C = 8'h43;
	localparam logic [7:0] CHAR_R = 8'h52;

	// One parsed line as handed to the executor
	typedef struct packed {
		cmd_e   cmd;
		value_t arg;
		logic   err;
	} result_t;

endpackage : parser_pkg

//--- hdl/parser_top.sv
// Top level of the command parser that wires the reader, parsers and executor together
module parser_top import reader_pkg::*, parser_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  char_t  in_char,
	input  logic   in_valid,
	output logic   in_full,
	output value_t out_value,
	output logic   out_valid,
	output logic   out_error
);

	// Reader side
	logic       rd_trigger;
	rd_status_t rd_status;
	char_t      rd_char;

	// Per-consumer reader ports
	logic       main_rd_trigger;
	logic       cmd_rd_trigger;
	logic       args_rd_trigger;
	rd_status_t main_status;
	rd_status_t cmd_status;
	rd_status_t args_status;

	// Main parser to subparsers
	logic       connect_cmd;
	logic       connect_args;
	logic       cmd_start;
	logic       args_start;
	logic       cmd_done;
	cmd_e       cmd;
	logic       cmd_err;
	logic       args_done;
	value_t     arg;
	logic       args_err;

	// Parsed lines
	result_t    result;
	logic       result_valid;

	char_reader u_char_reader (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_char    (in_char),
		.in_valid   (in_valid),
		.in_full    (in_full),
		.rd_trigger (rd_trigger),
		.rd_status  (rd_status),
		.rd_char    (rd_char)
	);

	parser_inner_connect u_inner_connect (
		.connect_cmd     (connect_cmd),
		.connect_args    (connect_args),
		.rd_status       (rd_status),
		.main_rd_trigger (main_rd_trigger),
		.cmd_rd_trigger  (cmd_rd_trigger),
		.args_rd_trigger (args_rd_trigger),
		.rd_trigger      (rd_trigger),
		.main_status     (main_status),
		.cmd_status      (cmd_status),
		.args_status     (args_status)
	);

	main_parser u_main_parser (
		.clk          (clk),
		.arst_n       (arst_n),
		.status       (main_status),
		.rd_char      (rd_char),
		.rd_trigger   (main_rd_trigger),
		.connect_cmd  (connect_cmd),
		.connect_args (connect_args),
		.cmd_start    (cmd_start),
		.args_start   (args_start),
		.cmd_done     (cmd_done),
		.cmd          (cmd),
		.cmd_err      (cmd_err),
		.args_done    (args_done),
		.arg          (arg),
		.args_err     (args_err),
		.result       (result),
		.result_valid (result_valid)
	);

	cmd_subparser u_cmd_subparser (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (cmd_start),
		.status     (cmd_status),
		.rd_char    (rd_char),
		.rd_trigger (cmd_rd_trigger),
		.cmd_done   (cmd_done),
		.cmd        (cmd),
		.cmd_err    (cmd_err)
	);

	args_subparser u_args_subparser (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (args_start),
		.status     (args_status),
		.rd_char    (rd_char),
		.rd_trigger (args_rd_trigger),
		.args_done  (args_done),
		.arg        (arg),
		.args_err   (args_err)
	);

	cmd_executor u_cmd_executor (
		.clk          (clk),
		.arst_n       (arst_n),
		.result       (result),
		.result_valid (result_valid),
		.out_value    (out_value),
		.out_valid    (out_valid),
		.out_error    (out_error)
	);

endmodule : parser_top

//--- hdl/reader_pkg.sv
// Types and sizes of the character reader, imported by the reader and by every consumer
package reader_pkg;

	// FIFO size
	// Depth must stay a power of two so the pointers wrap by themselves
	localparam int FIFO_DEPTH = 8;
	localparam int PTR_W      = $clog2(FIFO_DEPTH);

	// One ASCII character
	typedef logic [7:0] char_t;

	// Reader status as seen by one consumer
	typedef struct packed {
		// One-cycle pulse when the requested character is on rd_char
		logic done;
		// Reader idle and able to accept a trigger
		logic rdy;
		// FIFO holds nothing
		logic empty;
	} rd_status_t;

endpackage : reader_pkg

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module parser_tb -f vlog.f -o parser_sim > build.log 2>&1 \
	&& ./obj_dir/parser_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0

//--- verification/parser_stim.txt
// Words are 5 hex digits, kind then data: 0 = char then random gap, 1 = char with no gap,
// 2 = expected out_valid with out_value, 3 = expected out_error with out_value, F = end
00053 00020 00031 00032 00033 0000A                 // S 123
2007B
00052 0000A                                         // R
2007B
00053 00020 00036 00035 00035 00033 00030 0000A     // S 65530
2FFFA
00041 00020 00031 00030 0000A                       // A 10
20004
00041 00020 00037 00030 00030 00030 00030 0000A     // A 70000
21174
00043 0000A                                         // C
20000
00053 00020 00037 0000A                             // S 7
20007
00058 00020 00035 0000A                             // X 5
30007
00053 00020 00031 00061 0000A                       // S 1a
30007
00041 0000A                                         // A with bare newline
30007
00043 00020 00035 0000A                             // C 5
30007
00052 0000A                                         // R
20007
10041 10020 10030 10030 10030 10030 10030 10030     // A 000000000012 as a burst
10030 10030 10030 10030 10031 10032 1000A
20013
00052 0000A                                         // R
20013
F0000

//--- verification/parser_tb.sv
// Self-checking testbench for the command parser, replays the stimulus file from the project root
module parser_tb import reader_pkg::*, parser_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Kind nibble of a stimulus word
	typedef enum logic [3:0] {
		KIND_CHAR  = 4'h0,
		KIND_BURST = 4'h1,
		KIND_VALID = 4'h2,
		KIND_ERROR = 4'h3,
		KIND_END   = 4'hF
	} kind_e;

	// One character to send, burst means no idle gap after it
	typedef struct packed {
		logic  burst;
		char_t ch;
	} tx_char_t;

	// One expected executor output
	typedef struct packed {
		logic   is_err;
		value_t value;
	} expect_t;

	logic   clk;
	logic   arst_n;
	char_t  in_char;
	logic   in_valid;
	logic   in_full;
	value_t out_value;
	logic   out_valid;
	logic   out_error;

	logic [19:0] stim_mem [256];
	tx_char_t    char_q [$];
	expect_t     exp_q [$];
	logic [7:0]  lfsr;
	int          value_errors;
	int          other_errors;
	int          watchdog_cycles;
	logic        stim_loaded;
	logic        full_seen;

	parser_top UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_char   (in_char),
		.in_valid  (in_valid),
		.in_full   (in_full),
		.out_value (out_value),
		.out_valid (out_valid),
		.out_error (out_error)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] state);
		logic fb;
		fb = state[7] ^ state[5] ^ state[4] ^ state[3];
		return {state[6:0], fb};
	endfunction

	// Idle gap of 0 to 3 cycles, one LFSR step per bit
	task automatic draw_gap(output int gap);
		logic [1:0] bits;
		lfsr    = lfsr_next(lfsr);
		bits[0] = lfsr[0];
		lfsr    = lfsr_next(lfsr);
		bits[1] = lfsr[0];
		gap     = int'(bits);
	endtask

	// Split the file into the send queue and the expected queue
	task automatic load_stimulus();
		kind_e    kind;
		tx_char_t tc;
		expect_t  exp;
		int       idx;
		$readmemh("verification/parser_stim.txt", stim_mem);
		idx = 0;
		while (idx < 256 && stim_mem[idx][19:16] != KIND_END) begin
			kind = kind_e'(stim_mem[idx][19:16]);
			case (kind)
				KIND_CHAR, KIND_BURST: begin
					tc.burst = (kind == KIND_BURST);
					tc.ch    = stim_mem[idx][7:0];
					char_q.push_back(tc);
				end
				KIND_VALID, KIND_ERROR: begin
					exp.is_err = (kind == KIND_ERROR);
					exp.value  = stim_mem[idx][15:0];
					exp_q.push_back(exp);
				end
				default: begin
					other_errors++;
					$display("Unknown stimulus word %h at index %0d", stim_mem[idx], idx);
				end
			endcase
			idx++;
		end
	endtask

	// Compare one output pulse with the head of the expected queue
	task automatic check_output();
		expect_t exp;
		have_expect: assert (exp_q.size() != 0)
			else begin
				other_errors++;
				$display("Output pulse at %0t with no expected result left", $time);
			end
		if (exp_q.size() != 0) begin
			exp = exp_q.pop_front();
			valid_flag: assert (out_valid == !exp.is_err)
				else begin
					value_errors++;
					$display("CHECK FAILED at %0t: out_valid = %b, expected %b",
						$time, out_valid, !exp.is_err);
				end
			error_flag: assert (out_error == exp.is_err)
				else begin
					value_errors++;
					$display("CHECK FAILED at %0t: out_error = %b, expected %b",
						$time, out_error, exp.is_err);
				end
			// Errors must leave the register unchanged
			value_match: assert (out_value == exp.value)
				else begin
					value_errors++;
					$display("CHECK FAILED at %0t: out_value = %0d, expected %0d",
						$time, out_value, exp.value);
				end
		end
	endtask

	// Stimulus and end of run
	initial begin
		int       gap;
		tx_char_t tc;
		arst_n       = 1'b0;
		in_char      = '0;
		in_valid     = 1'b0;
		lfsr         = 8'd64;
		value_errors = 0;
		other_errors = 0;
		stim_loaded  = 1'b0;
		full_seen    = 1'b0;
		load_stimulus();
		// Generous per-character budget plus a fixed margin
		watchdog_cycles = char_q.size() * 40 + 25 * FIFO_DEPTH;
		stim_loaded     = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		// Empty FIFO out of reset
		reset_full: assert (in_full == 1'b0)
			else begin
				value_errors++;
				$display("CHECK FAILED at %0t: in_full = %b, expected 0", $time, in_full);
			end
		arst_n = 1'b1;
		while (char_q.size() != 0) begin
			tc = char_q.pop_front();
			// Hold while the FIFO is full
			while (in_full)
				@(negedge clk);
			in_char  = tc.ch;
			in_valid = 1'b1;
			@(negedge clk);
			in_valid = 1'b0;
			if (!tc.burst) begin
				draw_gap(gap);
				repeat (gap) @(negedge clk);
			end
		end
		while (exp_q.size() != 0)
			@(negedge clk);
		// Catch stray pulses after the last line
		repeat (20) @(negedge clk);
		// Burst line outruns the parser, so the FIFO has to fill
		full_check: assert (full_seen)
			else begin
				other_errors++;
				$display("FIFO never reported full during the burst line");
			end
		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Outputs are stable on the falling edge
	initial begin
		forever begin
			@(negedge clk);
			if (arst_n && in_full)
				full_seen = 1'b1;
			if (arst_n && (out_valid || out_error))
				check_output();
		end
	end

	// Watchdog
	initial begin
		wait (stim_loaded);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles with %0d results still expected",
			watchdog_cycles, exp_q.size());
		$display("Finished with errors");
		$finish;
	end

endmodule : parser_tb

//--- vlog.f
hdl/reader_pkg.sv
hdl/parser_pkg.sv
hdl/char_reader.sv
hdl/parser_inner_connect.sv
hdl/cmd_subparser.sv
hdl/args_subparser.sv
hdl/main_parser.sv
hdl/cmd_executor.sv
hdl/parser_top.sv
verification/parser_tb.sv
